// File: multicore_config.svh
`ifndef MULTICORE_CONFIG_SVH
`define MULTICORE_CONFIG_SVH

// Number of cores in the array, 1 to 22.
`define NUM_CORES 4

// Cycles between two successive core starts.
`define RST_STAGGER 12

// Samples taken per frame.
`define TAPS 4

// Core cycle period covering the capture, pipeline and idle phases.
`define FRAME_LEN 8

// Signed sample and result width.
`define DATA_W 31

// Port code width on req_in and out_en.
`define PORT_W 4

`endif

// File: core_pkg.sv
`include "multicore_config.svh"

package core_pkg;

	// Weight is core index plus one, held as a signed value.
	localparam int unsigned weight_w = $clog2(`NUM_CORES + 1) + 1;
	localparam int unsigned prod_w = `DATA_W + weight_w;
	localparam int unsigned acc_w = prod_w + $clog2(`TAPS); // Headroom for TAPS sums.

	typedef logic signed [`DATA_W-1:0] sample_t;
	typedef logic [`PORT_W-1:0] port_t;
	typedef logic signed [weight_w-1:0] weight_t;
	typedef logic signed [prod_w-1:0] prod_t;
	typedef logic signed [acc_w-1:0] acc_t;
	typedef logic [$clog2(`FRAME_LEN)-1:0] phase_t;

	// Port 1 is the only port in use.
	localparam port_t port_idle = '0;
	localparam port_t port_active = port_t'(1);

	// One core's emitted word.
	typedef struct packed {
		sample_t data;
		port_t out_en;
	} core_out_t;

endpackage

// File: array_pkg.sv
`include "multicore_config.svh"

package array_pkg;

	// One run level per core, bit i for core i.
	typedef logic [`NUM_CORES-1:0] run_mask_t;

	// All cores running.
	localparam run_mask_t run_all = '1;

	// Every core's result on its way to the arbiter.
	typedef core_pkg::core_out_t [`NUM_CORES-1:0] core_out_bus_t;

	// Every core's request code, straight to the top port.
	typedef core_pkg::port_t [`NUM_CORES-1:0] req_bus_t;

endpackage

// File: reset_sequencer.sv
`timescale 1ns/100ps

`include "multicore_config.svh"

module reset_sequencer (
	input logic clk,
	input logic rst_n,
	output array_pkg::run_mask_t run_mask
);

	import array_pkg::*;

	// Start time of the last core.
	localparam int unsigned last_start = (`NUM_CORES - 1) * `RST_STAGGER;
	// One spare count so the counter can step past the last start.
	localparam int unsigned cnt_w = $clog2(last_start + 2);

	logic [cnt_w-1:0] cnt;
	logic all_running;

	assign all_running = (run_mask == run_all);

	// Start counter runs freely and freezes once the array is up.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (!all_running) begin
			cnt <= cnt + 1'b1;
		end
	end

	// Core i starts when the counter reaches i times the stagger.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run_mask <= '0;
		end else begin
			for (int i = 0; i < `NUM_CORES; i++) begin
				if (cnt == cnt_w'(i * `RST_STAGGER)) begin
					run_mask[i] <= 1'b1; // Sticky until reset.
				end
			end
		end
	end

endmodule

// File: neuron_core.sv
`timescale 1ns/100ps

`include "multicore_config.svh"

module neuron_core #(
	parameter int unsigned core_index = 0
) (
	input logic clk,
	input logic rst_n,
	input logic run,
	input core_pkg::sample_t io_in,
	output core_pkg::port_t req_in,
	output core_pkg::core_out_t result
);

	import core_pkg::*;

	// Products arrive two phases after the first request.
	localparam phase_t acc_first = phase_t'(2);
	localparam phase_t acc_last = phase_t'(2 + `TAPS - 1);
	localparam phase_t emit_phase = phase_t'(2 + `TAPS);
	localparam phase_t phase_last = phase_t'(`FRAME_LEN - 1);

	localparam weight_t weight = weight_t'(core_index + 1);

	// Saturation bounds of a DATA_W result.
	localparam acc_t sat_max = acc_t'((2 ** (`DATA_W - 1)) - 1);
	localparam acc_t sat_min = acc_t'(-(2 ** (`DATA_W - 1)));

	phase_t phase;
	logic req;
	logic emit;

	sample_t sample_q;
	prod_t prod_q;
	acc_t acc_q;
	sample_t sat_data;

	// Frame phase counter holds at zero until the core is started.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= '0;
		end else if (run) begin
			if (phase == phase_last) begin
				phase <= '0;
			end else begin
				phase <= phase + 1'b1;
			end
		end
	end

	assign req = run && (phase < phase_t'(`TAPS));
	assign emit = run && (phase == emit_phase);

	assign req_in = req ? port_active : port_idle;

	// The first stage captures on the edge that closes a request cycle.
	always_ff @(posedge clk) begin
		if (req) begin
			sample_q <= io_in;
		end
	end

	// The second stage weights the captured sample.
	always_ff @(posedge clk) begin
		prod_q <= sample_q * weight;
	end

	// In the third stage the first product of a frame restarts the sum.
	always_ff @(posedge clk) begin
		if (run) begin
			if (phase == acc_first) begin
				acc_q <= prod_q;
			end else if (phase > acc_first && phase <= acc_last) begin
				acc_q <= acc_q + prod_q;
			end
		end
	end

	// Clamp the closed sum to the output range.
	always_comb begin
		if (acc_q > sat_max) begin
			sat_data = sample_t'(sat_max);
		end else if (acc_q < sat_min) begin
			sat_data = sample_t'(sat_min);
		end else begin
			sat_data = sample_t'(acc_q);
		end
	end

	// Emit for one cycle per frame.
	always_comb begin
		if (emit) begin
			result.data = sat_data;
			result.out_en = port_active;
		end else begin
			result.data = '0;
			result.out_en = port_idle;
		end
	end

endmodule

// File: output_arbiter.sv
`timescale 1ns/100ps

`include "multicore_config.svh"

module output_arbiter (
	input logic clk,
	input logic rst_n,
	input array_pkg::core_out_bus_t core_out_bus,
	output core_pkg::sample_t io_out,
	output core_pkg::port_t out_en
);

	import core_pkg::*;

	core_out_t winner;

	// Scan from the top so the lowest emitting index wins.
	always_comb begin
		winner.data = '0;
		winner.out_en = port_idle;
		for (int i = `NUM_CORES - 1; i >= 0; i--) begin
			if (core_out_bus[i].out_en == port_active) begin
				winner = core_out_bus[i];
			end
		end
	end

	// Losing results are dropped.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			io_out <= '0;
			out_en <= port_idle;
		end else begin
			io_out <= winner.data;
			out_en <= winner.out_en;
		end
	end

endmodule

// File: multicore.sv
`timescale 1ns/100ps

`include "multicore_config.svh"

module multicore (
	input logic clk,
	input logic rst_n,
	input core_pkg::sample_t io_in,
	output core_pkg::sample_t io_out,
	output core_pkg::port_t out_en,
	output array_pkg::req_bus_t req_in
);

	import array_pkg::*;

	run_mask_t run_mask;
	core_out_bus_t core_out_bus;

	reset_sequencer reset_sequencer_inst (
		.clk(clk),
		.rst_n(rst_n),
		.run_mask(run_mask)
	);

	// All cores share io_in.
	for (genvar i = 0; i < `NUM_CORES; i++) begin : g_core
		neuron_core #(
			.core_index(i)
		) neuron_core_inst (
			.clk(clk),
			.rst_n(rst_n),
			.run(run_mask[i]),
			.io_in(io_in),
			.req_in(req_in[i]),
			.result(core_out_bus[i])
		);
	end

	output_arbiter output_arbiter_inst (
		.clk(clk),
		.rst_n(rst_n),
		.core_out_bus(core_out_bus),
		.io_out(io_out),
		.out_en(out_en)
	);

endmodule

// File: tb_multicore.sv
`timescale 1ns/100ps

`include "multicore_config.svh"

module tb_multicore;

	import core_pkg::*;
	import array_pkg::*;

	localparam int clk_half = 5; // 10 ns period.
	localparam int reset_cycles = 16;
	localparam int target_pulses = 64;
	localparam int start_timeout = `NUM_CORES * `RST_STAGGER + 4 * `FRAME_LEN;
	localparam int pulse_timeout = target_pulses * `FRAME_LEN * 2;

	// Output range of a DATA_W signed result.
	localparam longint sat_hi = (longint'(1) << (`DATA_W - 1)) - 1;
	localparam longint sat_lo = -(longint'(1) << (`DATA_W - 1));

	logic clk;
	logic rst_n;
	sample_t io_in;
	sample_t io_out;
	port_t out_en;
	req_bus_t req_in;

	int cyc; // Cycles since reset release as counted at falling edges.
	int checks;
	int errors;
	int timeouts;
	int pulses_seen;
	int emit_cycles;
	int collisions;
	int dropped;
	int pos_sat;
	int neg_sat;
	int mode;

	int first_req[`NUM_CORES];
	int tap_cnt[`NUM_CORES];
	longint samples[`NUM_CORES][`TAPS];
	bit pend_valid[`NUM_CORES];
	int pend_cycle[`NUM_CORES];
	longint pend_value[`NUM_CORES];
	int pend_sat[`NUM_CORES]; // Plus one when clamped high, minus one when clamped low.

	multicore multicore_inst (
		.clk(clk),
		.rst_n(rst_n),
		.io_in(io_in),
		.io_out(io_out),
		.out_en(out_en),
		.req_in(req_in)
	);

	always #(clk_half) clk = ~clk;

	task automatic check_value(input string name, input logic signed [63:0] expected,
			input logic signed [63:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED %s at cycle %0d: expected %0d, actual %0d",
				name, cyc, expected, actual);
		end
	endtask

	task automatic check_quiet();
		check_value("reset req_in", 0, req_in);
		check_value("reset out_en", 0, out_en);
		check_value("reset io_out", 0, io_out);
	endtask

	// Small samples keep the sum inside the output range.
	function automatic sample_t pick_sample();
		case (mode)
			4, 5: return sample_t'($urandom);
			6: return sample_t'(sat_hi);
			7: return sample_t'(sat_lo);
			default: return sample_t'(int'($urandom % 131072) - 65536);
		endcase
	endfunction

	// Clamps the weighted sum of one frame and queues it for the output port.
	task automatic close_frame(input int core);
		longint sum;
		sum = 0;
		for (int k = 0; k < `TAPS; k++) begin
			sum += samples[core][k] * longint'(core + 1);
		end
		pend_sat[core] = 0;
		if (sum > sat_hi) begin
			pend_sat[core] = 1;
			sum = sat_hi;
		end else if (sum < sat_lo) begin
			pend_sat[core] = -1;
			sum = sat_lo;
		end
		// Last capture ends phase 3, emit is phase 6, arbiter adds one.
		pend_valid[core] = 1'b1;
		pend_cycle[core] = cyc + 4;
		pend_value[core] = sum;
	endtask

	task automatic capture_samples(input sample_t value);
		for (int i = 0; i < `NUM_CORES; i++) begin
			if (req_in[i] == port_t'(1)) begin
				samples[i][tap_cnt[i]] = longint'(value);
				tap_cnt[i]++;
				if (tap_cnt[i] == `TAPS) begin
					close_frame(i);
					tap_cnt[i] = 0;
				end
			end
		end
	endtask

	// Request window follows from the start time and the frame length.
	task automatic check_requests();
		int start;
		logic signed [63:0] expected;
		for (int i = 0; i < `NUM_CORES; i++) begin
			start = 1 + i * `RST_STAGGER;
			if (cyc >= start && (cyc - start) % `FRAME_LEN < `TAPS) begin
				expected = 1;
			end else begin
				expected = 0;
			end
			check_value($sformatf("req_in window core %0d", i), expected, req_in[i]);
			if (req_in[i] == port_t'(1) && first_req[i] < 0) begin
				first_req[i] = cyc;
			end
		end
	endtask

	task automatic check_output();
		int winner;
		int hits;
		winner = -1;
		hits = 0;
		for (int i = 0; i < `NUM_CORES; i++) begin
			if (pend_valid[i] && pend_cycle[i] == cyc) begin
				if (winner < 0) begin
					winner = i; // Lowest index wins.
				end
				hits++;
				pend_valid[i] = 1'b0;
			end
		end
		if (winner >= 0) begin
			check_value($sformatf("frame result core %0d", winner),
				pend_value[winner], io_out);
			check_value("out_en pulse", 1, out_en);
			emit_cycles++;
			if (pend_sat[winner] > 0) begin
				pos_sat++;
			end else if (pend_sat[winner] < 0) begin
				neg_sat++;
			end
			if (hits > 1) begin
				collisions++;
				dropped += hits - 1;
			end
		end else begin
			check_value("out_en idle", 0, out_en);
			check_value("io_out idle", 0, io_out);
		end
		if (out_en == port_t'(1)) begin
			pulses_seen++;
		end
	endtask

	// Checks what the DUT shows in one cycle and then drives the next sample.
	task automatic step_cycle();
		sample_t next_in;
		@(negedge clk);
		cyc++;
		check_output();
		check_requests();
		if (cyc % `FRAME_LEN == 1) begin
			mode = $urandom % 8; // Aligned with core 0 frames.
		end
		next_in = pick_sample();
		io_in = next_in;
		capture_samples(next_in);
	endtask

	task automatic wait_all_started();
		int waited;
		waited = 0;
		while (first_req[`NUM_CORES-1] < 0 && waited < start_timeout) begin
			step_cycle();
			waited++;
		end
		if (first_req[`NUM_CORES-1] < 0) begin
			timeouts++;
			$display("Timeout: core %0d never requested a sample within %0d cycles",
				`NUM_CORES - 1, waited);
		end
	endtask

	task automatic run_frames();
		int waited;
		waited = 0;
		while (pulses_seen < target_pulses && waited < pulse_timeout) begin
			step_cycle();
			waited++;
		end
		if (pulses_seen < target_pulses) begin
			timeouts++;
			$display("Timeout: only %0d of %0d output pulses seen in %0d cycles",
				pulses_seen, target_pulses, waited);
		end
	endtask

	task automatic check_totals();
		for (int i = 1; i < `NUM_CORES; i++) begin
			check_value($sformatf("staggered start core %0d", i),
				first_req[0] + i * `RST_STAGGER, first_req[i]);
		end
		check_value("pulse count", emit_cycles, pulses_seen);
		if (pos_sat == 0) begin
			errors++;
			$display("No output pulse carried a sum clamped at the positive limit");
		end
		if (neg_sat == 0) begin
			errors++;
			$display("No output pulse carried a sum clamped at the negative limit");
		end
		// Cores two apart share emit cycles when twice the stagger fills whole frames.
		if (`NUM_CORES > 2 && (2 * `RST_STAGGER) % `FRAME_LEN == 0
				&& collisions == 0) begin
			errors++;
			$display("No cycle had two cores emitting together");
		end
	endtask

	task automatic finish_run();
		$display(
			"Checks: %0d, errors: %0d, timeouts: %0d, pulses: %0d, collisions: %0d, dropped: %0d",
			checks, errors, timeouts, pulses_seen, collisions, dropped);
		if (errors == 0 && timeouts == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		io_in = '0;
		cyc = 0;
		checks = 0;
		errors = 0;
		timeouts = 0;
		pulses_seen = 0;
		emit_cycles = 0;
		collisions = 0;
		dropped = 0;
		pos_sat = 0;
		neg_sat = 0;
		mode = 0;
		for (int i = 0; i < `NUM_CORES; i++) begin
			first_req[i] = -1;
			tap_cnt[i] = 0;
			pend_valid[i] = 1'b0;
			pend_sat[i] = 0;
		end
		void'($urandom(93));

		for (int n = 0; n < reset_cycles; n++) begin
			@(negedge clk);
			check_quiet();
		end
		rst_n = 1'b1; // Core 0 starts at the next rising edge.

		wait_all_started();
		if (timeouts == 0) begin
			run_frames();
		end
		if (timeouts == 0) begin
			check_totals();
		end
		finish_run();
	end

endmodule

// File: tb.f
+incdir+.
core_pkg.sv
array_pkg.sv
reset_sequencer.sv
neuron_core.sv
output_arbiter.sv
multicore.sv
tb_multicore.sv

// File: Bender.yml
package:
  name: multicore

sources:
  - include_dirs:
      - .
    files:
      - core_pkg.sv
      - array_pkg.sv
      - reset_sequencer.sv
      - neuron_core.sv
      - output_arbiter.sv
      - multicore.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_multicore.sv
